// ==== can_host_top.f ====
src/can_host_pkg.sv
src/can_reg_mux.sv
src/can_bus_writer.sv
src/can_host_ctrl.sv
src/can_host_top.sv
tb/tb_can_host.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the CAN host loader testbench with Verilator.
# Exits non-zero unless the simulation log holds the pass message.

set -u
cd "$(dirname "$0")" || exit 1

top=tb_can_host
flist=can_host_top.f
obj_dir=build
build_log=build.log
sim_log=sim.log

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

rm -rf "$obj_dir"
rm -f "$build_log" "$sim_log"

# Build the simulation binary
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module "$top" -Mdir "$obj_dir" -f "$flist" > "$build_log" 2>&1
status=$?
if [ "$status" -ne 0 ]; then
  cat "$build_log"
  echo "Compile failed with status $status"
  exit 1
fi

# Run it
"./$obj_dir/V$top" > "$sim_log" 2>&1
status=$?
cat "$sim_log"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Pass only if the testbench reported a pass
if grep -qF '*** TEST PASSED ***' "$sim_log"; then
  echo "Result: pass"
  exit 0
else
  echo "Result: fail"
  exit 1
fi

// ==== src/can_bus_writer.sv ====
`timescale 1ns/1ps
module can_bus_writer (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   wr_valid,
  input  can_host_pkg::can_wr_s  wr,
  input  logic                   wr_last,       // Beat closes the series
  output logic                   wr_ready,
  output logic                   reg_valid,
  output can_host_pkg::can_wr_s  reg_wr,
  input  logic                   reg_ready,
  output logic                   done           // Last beat left this cycle
);

  logic last_q;                                 // Held entry is the last one

  // Empty, or emptying on this edge
  assign wr_ready = !reg_valid || reg_ready;
  assign done     = reg_valid && reg_ready && last_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      reg_valid <= 1'b0;
      last_q    <= 1'b0;
    end else if (wr_ready) begin
      reg_valid <= wr_valid;                    // Load or clear on drain
      last_q    <= wr_valid && wr_last;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_valid && wr_ready) begin
      reg_wr <= wr;                             // Payload only
    end
  end

  // A stalled beat must stay offered and unchanged until the core takes it
  a_hold_stall: assert property (
    @(posedge clk) disable iff (!arst_n)
    reg_valid && !reg_ready |=> reg_valid && $stable(reg_wr)
  ) else $error("reg_wr changed under back-pressure");

endmodule

// ==== src/can_host_ctrl.sv ====
`timescale 1ns/1ps
module can_host_ctrl #(
  parameter int init_count = 4                  // Length of the init series
) (
  input  logic                                clk,
  input  logic                                arst_n,
  input  logic                                cmd_valid,
  input  can_host_pkg::can_cmd_s              cmd,
  output logic                                cmd_ready,
  output can_host_pkg::can_op_e               op,
  output can_host_pkg::can_msg_u              msg,
  output logic [can_host_pkg::step_w-1:0]     step,
  input  logic                                last_step,
  output logic                                wr_valid,
  input  logic                                wr_ready,
  input  logic                                done
);

  typedef enum logic [1:0] {
    st_idle  = 2'd0,                            // Waiting for a command
    st_issue = 2'd1,                            // Offering writes to the writer
    st_drain = 2'd2                             // Last write still in the writer
  } state_e;

  state_e state;

  assign cmd_ready = (state == st_idle);
  assign wr_valid  = (state == st_issue);       // One beat per step

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= st_idle;
      op    <= can_host_pkg::op_init;
      step  <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (cmd_valid) begin
            state <= st_issue;
            op    <= cmd.op;                    // Latch opcode on accept
            step  <= '0;
          end
        end
        st_issue: begin
          if (wr_ready) begin                   // Beat taken
            if (last_step) begin
              state <= st_drain;
            end else begin
              step <= step + can_host_pkg::step_w'(1);
            end
          end
        end
        st_drain: begin
          if (done) begin
            state <= st_idle;                   // cmd_ready back next cycle
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Message held for the whole series
  always_ff @(posedge clk) begin
    if (cmd_valid && cmd_ready) begin
      msg <= cmd.msg;
    end
  end

  // Init series must fit in the step counter
  initial begin
    if (init_count < 1 || init_count > can_host_pkg::init_words) begin
      $error("init_count %0d outside init_table", init_count);
    end
  end

  // Previous series fully out of the writer when a new command is taken
  a_idle_on_accept: assert property (
    @(posedge clk) disable iff (!arst_n)
    cmd_valid && cmd_ready |-> wr_ready
  ) else $error("command accepted while busy");

  // Writer only reports completion for a series this FSM is draining
  a_done_in_drain: assert property (
    @(posedge clk) disable iff (!arst_n)
    done |-> state == st_drain
  ) else $error("done outside drain state");

endmodule

// ==== src/can_host_pkg.sv ====
package can_host_pkg;

  // Host command opcodes
  typedef enum logic [1:0] {
    op_init    = 2'd0,                          // Load configuration table
    op_tx      = 2'd1,                          // Transmit one message
    op_trim    = 2'd2,                          // Transmit trim test pattern
    op_bus_rst = 2'd3                           // Reset bus and clear interrupts
  } can_op_e;

  // Message fields, data0 is the most significant byte
  typedef struct packed {
    logic       unused;                         // Bit 75
    logic [10:0] id;                            // Bits 74..64
    logic [7:0]  data0;                         // Bits 63..56
    logic [7:0]  data1;
    logic [7:0]  data2;
    logic [7:0]  data3;
    logic [7:0]  data4;
    logic [7:0]  data5;
    logic [7:0]  data6;
    logic [7:0]  data7;                         // Bits 7..0
  } can_msg_s;

  // Same 76 bits, seen as fields or as one raw word
  typedef union packed {
    can_msg_s    f;
    logic [75:0] raw;
  } can_msg_u;

  typedef struct packed {
    can_op_e  op;
    can_msg_u msg;
  } can_cmd_s;

  // One register port beat
  typedef struct packed {
    logic [4:0]  addr;
    logic [15:0] data;
  } can_wr_s;

  // Core register map
  localparam logic [4:0] reg_tx_id   = 5'h0C;   // Transmit identifier
  localparam logic [4:0] reg_tx_d12  = 5'h0A;   // Transmit data 1-2
  localparam logic [4:0] reg_tx_d34  = 5'h09;   // Transmit data 3-4
  localparam logic [4:0] reg_tx_d56  = 5'h08;   // Transmit data 5-6
  localparam logic [4:0] reg_tx_d78  = 5'h07;   // Transmit data 7-8
  localparam logic [4:0] reg_tx_ctrl = 5'h0D;   // Transmit control
  localparam logic [4:0] reg_general = 5'h0E;   // General control
  localparam logic [4:0] reg_irq     = 5'h12;   // Interrupt register

  localparam logic [15:0] tx_ctrl_word = 16'h8008; // Start transmission
  localparam logic [15:0] rst_irq_word = 16'h8070; // Clear pending irqs
  localparam logic [15:0] gen_word     = 16'h009C; // Normal operating mode

  // Most transitions possible on the bus
  localparam logic [75:0] trim_pattern = {12'h555, 64'hAAAA_AAAA_AAAA_AAAA};

  localparam int init_words = 4;
  localparam int step_w     = 3;                // Covers the 7-write series

  // Configuration writes, issued in order
  localparam can_wr_s init_table [0:init_words-1] = '{
    '{addr: 5'h0F, data: 16'h0004},             // Prescaler
    '{addr: 5'h10, data: 16'h0125},             // Bit timing
    '{addr: 5'h11, data: 16'h00F0},             // Interrupt enables
    '{addr: reg_general, data: gen_word}        // Leave config mode
  };

endpackage

// ==== src/can_host_top.sv ====
`timescale 1ns/1ps
module can_host_top #(
  parameter int init_count = can_host_pkg::init_words // Shorter table allowed
) (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   cmd_valid,
  input  can_host_pkg::can_cmd_s cmd,
  output logic                   cmd_ready,
  output logic                   reg_valid,
  output can_host_pkg::can_wr_s  reg_wr,
  input  logic                   reg_ready
);

  can_host_pkg::can_op_e              op;       // Latched opcode
  can_host_pkg::can_msg_u             msg;      // Latched message
  logic [can_host_pkg::step_w-1:0]    step;
  can_host_pkg::can_wr_s              mux_wr;   // Word for current step
  logic                               last_step;
  logic                               wr_valid;
  logic                               wr_ready;
  logic                               done;

  can_host_ctrl #(.init_count(init_count)) u_ctrl (
    .clk       (clk),
    .arst_n    (arst_n),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .cmd_ready (cmd_ready),
    .op        (op),
    .msg       (msg),
    .step      (step),
    .last_step (last_step),
    .wr_valid  (wr_valid),
    .wr_ready  (wr_ready),
    .done      (done)
  );

  can_reg_mux #(.init_count(init_count)) u_mux (
    .op        (op),
    .msg       (msg),
    .step      (step),
    .wr        (mux_wr),
    .last_step (last_step)
  );

  can_bus_writer u_writer (
    .clk       (clk),
    .arst_n    (arst_n),
    .wr_valid  (wr_valid),
    .wr        (mux_wr),
    .wr_last   (last_step),                     // Tags the closing beat
    .wr_ready  (wr_ready),
    .reg_valid (reg_valid),
    .reg_wr    (reg_wr),
    .reg_ready (reg_ready),
    .done      (done)
  );

endmodule

// ==== src/can_reg_mux.sv ====
`timescale 1ns/1ps
module can_reg_mux #(
  parameter int init_count = 4                  // Used entries of init_table
) (
  input  can_host_pkg::can_op_e               op,
  input  can_host_pkg::can_msg_u              msg,
  input  logic [can_host_pkg::step_w-1:0]     step,
  output can_host_pkg::can_wr_s               wr,
  output logic                                last_step
);

  localparam int idx_w = $clog2(can_host_pkg::init_words); // Table index width

  can_host_pkg::can_msg_u src;                  // Message actually sent

  // Trim pattern is raw, but decoded through the same fields
  always_comb begin
    if (op == can_host_pkg::op_trim) begin
      src.raw = can_host_pkg::trim_pattern;
    end else begin
      src = msg;
    end
  end

  always_comb begin
    wr        = '0;                             // Unused steps write nothing
    last_step = 1'b0;
    case (op)
      can_host_pkg::op_init: begin
        wr        = can_host_pkg::init_table[step[idx_w-1:0]];
        last_step = (step == can_host_pkg::step_w'(init_count - 1));
      end
      can_host_pkg::op_tx, can_host_pkg::op_trim: begin
        last_step = (step == can_host_pkg::step_w'(6));
        case (step)
          3'd0: wr = '{can_host_pkg::reg_tx_id, {src.f.id, 5'h00}};   // Id over 5 zeros
          3'd1: wr = '{can_host_pkg::reg_tx_d12, {src.f.data0, src.f.data2}};
          3'd2: wr = '{can_host_pkg::reg_tx_d34, {src.f.data1, src.f.data3}};
          3'd3: wr = '{can_host_pkg::reg_tx_d56, {src.f.data7, src.f.data6}}; // Swapped
          3'd4: wr = '{can_host_pkg::reg_tx_d78, {src.f.data5, src.f.data4}}; // Swapped
          3'd5: wr = '{can_host_pkg::reg_general, can_host_pkg::gen_word};
          3'd6: wr = '{can_host_pkg::reg_tx_ctrl, can_host_pkg::tx_ctrl_word}; // Kick tx
          default: wr = '0;
        endcase
      end
      can_host_pkg::op_bus_rst: begin
        last_step = (step == can_host_pkg::step_w'(1));
        case (step)
          3'd0: wr = '{can_host_pkg::reg_general, can_host_pkg::gen_word};
          3'd1: wr = '{can_host_pkg::reg_irq, can_host_pkg::rst_irq_word}; // Clear irqs
          default: wr = '0;
        endcase
      end
      default: begin
        wr        = '0;
        last_step = 1'b0;
      end
    endcase
  end

endmodule

// ==== tb/tb_can_host.sv ====
`timescale 1ns/1ps
module tb_can_host;

  localparam int init_n   = can_host_pkg::init_words; // Full init table
  localparam int bp_count = 20;                        // Random tx under stalls
  localparam int num_cmds = 4 + bp_count + 4;          // All commands issued

  logic                   clk;
  logic                   arst_n;
  logic                   cmd_valid;
  can_host_pkg::can_cmd_s cmd;
  logic                   cmd_ready;
  logic                   reg_valid;
  can_host_pkg::can_wr_s  reg_wr;
  logic                   reg_ready = 1'b0;            // Core model output

  bit                     stall_en = 1'b0;             // Random back-pressure on
  can_host_pkg::can_wr_s  got_q[$];                    // Every write seen by core
  can_host_pkg::can_wr_s  exp_q[$];                    // Series for current test
  int                     rd_idx = 0;                  // First unchecked write
  int                     errors = 0;
  int                     checks = 0;

  can_host_top #(.init_count(init_n)) DUT (
    .clk       (clk),
    .arst_n    (arst_n),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .cmd_ready (cmd_ready),
    .reg_valid (reg_valid),
    .reg_wr    (reg_wr),
    .reg_ready (reg_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Core register port, records each completed write
  always @(posedge clk) begin : core_model
    logic [31:0] rnd;
    if (reg_valid && reg_ready) begin
      got_q.push_back(reg_wr);
    end
    rnd = $urandom();
    reg_ready <= stall_en ? (rnd[1:0] != 2'b00) : 1'b1; // About 1 in 4 stalls
  end

  initial begin
    #(num_cmds * 2000);
    $display("Timeout: the commands did not finish in time");
    $display("*** TEST FAILED ***");
    $finish;
  end

  function automatic void push_exp(logic [4:0] addr, logic [15:0] data);
    can_host_pkg::can_wr_s w;
    w.addr = addr;
    w.data = data;
    exp_q.push_back(w);
  endfunction

  // Expected series, message bytes taken straight from the raw bit ranges
  function automatic void add_expected(can_host_pkg::can_op_e op, logic [75:0] m_in);
    logic [75:0] m;
    m = (op == can_host_pkg::op_trim) ? can_host_pkg::trim_pattern : m_in;
    case (op)
      can_host_pkg::op_init: begin
        for (int i = 0; i < init_n; i++) begin
          exp_q.push_back(can_host_pkg::init_table[i]);
        end
      end
      can_host_pkg::op_tx, can_host_pkg::op_trim: begin
        push_exp(can_host_pkg::reg_tx_id, {m[74:64], 5'h00});    // Id over zeros
        push_exp(can_host_pkg::reg_tx_d12, {m[63:56], m[47:40]}); // data0, data2
        push_exp(can_host_pkg::reg_tx_d34, {m[55:48], m[39:32]}); // data1, data3
        push_exp(can_host_pkg::reg_tx_d56, {m[7:0], m[15:8]});    // data7, data6
        push_exp(can_host_pkg::reg_tx_d78, {m[23:16], m[31:24]}); // data5, data4
        push_exp(can_host_pkg::reg_general, can_host_pkg::gen_word);
        push_exp(can_host_pkg::reg_tx_ctrl, can_host_pkg::tx_ctrl_word);
      end
      default: begin
        push_exp(can_host_pkg::reg_general, can_host_pkg::gen_word);
        push_exp(can_host_pkg::reg_irq, can_host_pkg::rst_irq_word);
      end
    endcase
  endfunction

  function automatic logic [75:0] rand_msg();
    logic [95:0] r;
    r = {$urandom(), $urandom(), $urandom()};
    return r[75:0];
  endfunction

  task automatic check_wr(input int idx, input can_host_pkg::can_wr_s got,
                          input can_host_pkg::can_wr_s exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: reg_wr beat %0d got addr %h data %h, expected addr %h data %h",
               idx, got.addr, got.data, exp.addr, exp.data);
    end
  endtask

  task automatic check_count(input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("Error: write count got %h expected %h", got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s got %h expected %h", name, got, exp);
    end
  endtask

  // Offer a command until taken, optionally keep cmd_valid high afterwards
  task automatic send_cmd(input can_host_pkg::can_cmd_s c, input bit keep_valid);
    cmd_valid <= 1'b1;
    cmd       <= c;
    do @(posedge clk); while (!cmd_ready);   // Accepted on this edge
    if (!keep_valid) begin
      cmd_valid <= 1'b0;
    end
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (!cmd_ready && cycles < 1000);
    if (!cmd_ready) begin
      errors++;
      $display("Error: DUT stayed busy for %0d cycles after a command", cycles);
    end
  endtask

  task automatic compare_series();
    int n;
    n = got_q.size() - rd_idx;
    check_count(n, exp_q.size());
    for (int i = 0; i < exp_q.size() && i < n; i++) begin
      check_wr(i, got_q[rd_idx + i], exp_q[i]);
    end
    rd_idx = got_q.size();
    exp_q.delete();
  endtask

  task automatic run_cmd(input can_host_pkg::can_op_e op, input logic [75:0] m);
    can_host_pkg::can_cmd_s c;
    c.op      = op;
    c.msg.raw = m;
    add_expected(op, m);
    send_cmd(c, 1'b0);
    wait_idle();
    compare_series();
  endtask

  task automatic test_init();
    check_flag("cmd_ready", cmd_ready, 1'b1);           // Idle out of reset
    check_flag("reg_valid", reg_valid, 1'b0);
    run_cmd(can_host_pkg::op_init, '0);
  endtask

  task automatic test_tx();
    run_cmd(can_host_pkg::op_tx, {1'b0, 11'h3A7, 64'h1122_3344_5566_7788});
  endtask

  task automatic test_trim();
    run_cmd(can_host_pkg::op_trim, rand_msg());         // Message must be ignored
  endtask

  task automatic test_bus_rst();
    run_cmd(can_host_pkg::op_bus_rst, rand_msg());
  endtask

  task automatic test_backpressure();
    stall_en = 1'b1;
    for (int i = 0; i < bp_count; i++) begin
      run_cmd(can_host_pkg::op_tx, rand_msg());
    end
  endtask

  // cmd_valid stays high from the first offer to the last acceptance
  task automatic test_back_to_back();
    can_host_pkg::can_cmd_s c;
    can_host_pkg::can_op_e  ops [4];
    ops = '{can_host_pkg::op_init, can_host_pkg::op_tx,
            can_host_pkg::op_bus_rst, can_host_pkg::op_trim};
    for (int i = 0; i < 4; i++) begin
      c.op      = ops[i];
      c.msg.raw = rand_msg();
      add_expected(c.op, c.msg.raw);
      send_cmd(c, i < 3);
    end
    wait_idle();
    compare_series();                                   // Order proves no interleave
  endtask

  initial begin
    void'($urandom(32'hb910a20a));
    arst_n    = 1'b0;
    cmd_valid = 1'b0;
    cmd       = '0;
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    test_init();
    test_tx();
    test_trim();
    test_bus_rst();
    test_backpressure();
    test_back_to_back();
    $display("Run complete: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
